// File: compile.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_btb.sv
verilog/fetch_stage_reg.sv
verilog/branch_decode.sv
verilog/fetch_csr.sv
verilog/fetch_unit.sv
dv/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: dv/fetch_tb.sv
// testbench for the fetch unit
// clock, reset, instruction memory model, register accesses and checks
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int TIMEOUT = 2000;
  localparam logic [31:0] NOP_WORD = 32'h47ff041f;
  // bsr at 0x1038 jumps to 0x1060, br at 0x106c jumps back to 0x1000
  localparam logic [31:0] BSR_WORD = {`FETCH_OP_BSR, 5'd26, 21'd9};
  localparam logic [31:0] BR_WORD  = {`FETCH_OP_BR, 5'd31, 21'h1fffe4};

  logic clock;
  logic reset_n;
  logic [`FETCH_PC_W-1:0] fetch_pc_o;
  logic [`FETCH_SLOTS*`FETCH_INST_W-1:0] inst_bundle_i;
  logic instbuf_full_i;
  logic flush_i;
  logic [`FETCH_PC_W-1:0] flush_pc_i;
  fetch_bundle_t dec_bundle_o;
  logic [`FETCH_CSR_AW-1:0] awaddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;
  logic [`FETCH_CSR_AW-1:0] araddr;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] rdata;

  integer seed = 32'hfcfed4c0;
  logic hold_stall;
  logic adv_q;
  logic [`FETCH_PC_W-1:0] exp_pc;
  int bundle_count;
  int branch_count;
  int ov_base;
  logic [31:0] rd_val;

  fetch_unit fetch_unit_i (
    .clock (clock), .reset_n (reset_n), .fetch_pc_o (fetch_pc_o),
    .inst_bundle_i (inst_bundle_i), .instbuf_full_i (instbuf_full_i),
    .flush_i (flush_i), .flush_pc_i (flush_pc_i), .dec_bundle_o (dec_bundle_o),
    .s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
    .s_axil_wdata_i (wdata), .s_axil_wstrb_i (wstrb), .s_axil_wvalid_i (wvalid),
    .s_axil_wready_o (wready), .s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid),
    .s_axil_bready_i (bready), .s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready), .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp),
    .s_axil_rvalid_o (rvalid), .s_axil_rready_i (rready)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////
  // failure handling
  ////////////////////
  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (exp === act) else begin
      $display("Error %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////
  // memory model
  ////////////////////
  function automatic logic [31:0] word_at(input logic [63:0] addr);
    case (addr)
      64'h1038: return BSR_WORD;
      64'h106c: return BR_WORD;
      default:  return NOP_WORD;
    endcase
  endfunction

  // bundle follows f1, so it moves only on loading edges
  always @(posedge clock) begin
    if (reset_n && (!instbuf_full_i || flush_i)) begin
      for (int i = 0; i < `FETCH_SLOTS; i++) begin
        inst_bundle_i[i*32 +: 32] <= word_at(fetch_pc_o + 64'(4 * i));
      end
    end
  end

  always @(posedge clock) begin
    instbuf_full_i <= hold_stall ? 1'b1 : (($random(seed) & 3) == 0);
  end

  ////////////////////
  // bundle checker
  ////////////////////
  task automatic check_bundle(input fetch_bundle_t b);
    logic [7:0] mask;
    logic [63:0] next_pc;
    logic [31:0] w;
    bit found;
    mask = '1;
    next_pc = exp_pc + 64'd32;
    found = 0;
    check_value("bundle pc", exp_pc, b.pc);
    for (int i = 0; i < `FETCH_SLOTS; i++) begin
      w = word_at(exp_pc + 64'(4 * i));
      check_value("bundle word", 64'(w), 64'(b.inst[i]));
      if (!found && (w[31:26] == `FETCH_OP_BR || w[31:26] == `FETCH_OP_BSR)) begin
        found = 1;
        mask = 8'((16'd1 << (i + 1)) - 1);
        next_pc = exp_pc + 64'(4 * i) + 64'd4 + {{41{w[20]}}, w[20:0], 2'b00};
      end
    end
    check_value("bundle mask", 64'(mask), 64'(b.valid));
    bundle_count++;
    if (found) branch_count++;
    exp_pc = next_pc;
  endtask

  always @(posedge clock) begin
    if (reset_n) begin
      if (adv_q && |dec_bundle_o.valid) check_bundle(dec_bundle_o);
      // nothing fetched before the flush may follow it
      if (flush_i) exp_pc = flush_pc_i;
    end
    adv_q <= reset_n && !instbuf_full_i && !flush_i;
  end

  a_stall_stable: assert property (
    @(posedge clock) disable iff (!reset_n)
    instbuf_full_i && !flush_i |=> $stable(dec_bundle_o)
  ) else begin
    $display("dec_bundle_o changed while the instruction buffer was full");
    stop_run();
  end

  // the flush pc goes straight to f0
  a_flush_pc: assert property (
    @(posedge clock) disable iff (!reset_n)
    flush_i |=> fetch_pc_o == $past(flush_pc_i)
  ) else begin
    $display("fetch_pc_o did not move to the flush pc");
    stop_run();
  end

  ////////////////////
  // AXI4-Lite accesses
  ////////////////////
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
    int t;
    @(posedge clock);
    awaddr <= addr;
    wdata <= data;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    bready <= 1'b1;
    t = 0;
    do begin
      @(negedge clock);
      t++;
    end while (!awready && t < TIMEOUT);
    if (!awready) begin
      $display("register write was never accepted");
      stop_run();
    end
    check_value("write data ready", 64'd1, 64'(wready));
    @(posedge clock);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    t = 0;
    do begin
      @(negedge clock);
      t++;
    end while (!bvalid && t < TIMEOUT);
    if (!bvalid) begin
      $display("register write got no response");
      stop_run();
    end
    check_value("write response", 64'd0, 64'(bresp));
    @(posedge clock);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    int t;
    @(posedge clock);
    araddr <= addr;
    arvalid <= 1'b1;
    t = 0;
    do begin
      @(negedge clock);
      t++;
    end while (!arready && t < TIMEOUT);
    if (!arready) begin
      $display("register read was never accepted");
      stop_run();
    end
    @(posedge clock);
    arvalid <= 1'b0;
    rready <= 1'b1;
    t = 0;
    do begin
      @(negedge clock);
      t++;
    end while (!rvalid && t < TIMEOUT);
    if (!rvalid) begin
      $display("register read got no data");
      stop_run();
    end
    check_value("read response", 64'd0, 64'(rresp));
    data = rdata;
    @(posedge clock);
    rready <= 1'b0;
  endtask

  task automatic run_branches(input int n);
    int target;
    int t;
    target = branch_count + n;
    hold_stall <= 1'b0;
    t = 0;
    while (branch_count < target && t < TIMEOUT) begin
      @(negedge clock);
      t++;
    end
    if (branch_count < target) begin
      $display("branch bundles stopped arriving at decode");
      stop_run();
    end
    hold_stall <= 1'b1;
    repeat (4) @(posedge clock);
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    reset_n = 1'b0;
    inst_bundle_i = '0;
    instbuf_full_i = 1'b1;
    flush_i = 1'b0;
    flush_pc_i = '0;
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    hold_stall = 1'b0;
    adv_q = 1'b0;
    exp_pc = `FETCH_RESET_PC;
    bundle_count = 0;
    branch_count = 0;
    ov_base = 0;
    wstrb = 4'hf;
    repeat (16) @(posedge clock);
    reset_n <= 1'b1;

    // BTB off, every branch overrides
    run_branches(4);
    axil_read(`CSR_CTRL, rd_val);
    check_value("ctrl after reset", 64'd0, 64'(rd_val));
    axil_read(`CSR_BUNDLES, rd_val);
    check_value("bundles btb off", 64'(bundle_count), 64'(rd_val));
    axil_read(`CSR_OVERRIDES, rd_val);
    check_value("overrides btb off", 64'(branch_count), 64'(rd_val));
    ov_base = branch_count;

    // each of the two loop branches trains once, then hits
    axil_write(`CSR_CTRL, 32'h1);
    axil_read(`CSR_CTRL, rd_val);
    check_value("ctrl enable", 64'd1, 64'(rd_val));
    run_branches(4);
    axil_read(`CSR_OVERRIDES, rd_val);
    check_value("overrides training", 64'(ov_base + 2), 64'(rd_val));
    run_branches(4);
    axil_read(`CSR_OVERRIDES, rd_val);
    check_value("overrides trained", 64'(ov_base + 2), 64'(rd_val));

    // clear pulse, the loop has to train again
    axil_write(`CSR_CTRL, 32'h3);
    axil_read(`CSR_CTRL, rd_val);
    check_value("ctrl clear bit", 64'd1, 64'(rd_val));
    run_branches(4);
    axil_read(`CSR_OVERRIDES, rd_val);
    check_value("overrides after clear", 64'(ov_base + 4), 64'(rd_val));

    // retire flush to a bundle the loop itself never delivers
    hold_stall <= 1'b0;
    repeat (5) @(posedge clock);
    flush_i <= 1'b1;
    flush_pc_i <= 64'h1040;
    @(posedge clock);
    flush_i <= 1'b0;
    run_branches(3);
    axil_read(`CSR_BUNDLES, rd_val);
    check_value("bundles total", 64'(bundle_count), 64'(rd_val));

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: verilog/fetch_unit.sv
// two stage fetch unit top level
// f0 pc generation and BTB, f1 branch decode, decode register, CSR block
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_unit (
  input  logic                                 clock,
  input  logic                                 reset_n,
  output logic [`FETCH_PC_W-1:0]               fetch_pc_o,
  input  logic [`FETCH_SLOTS*`FETCH_INST_W-1:0] inst_bundle_i,
  input  logic                                 instbuf_full_i,
  input  logic                                 flush_i,
  input  logic [`FETCH_PC_W-1:0]               flush_pc_i,
  output fetch_pkg::fetch_bundle_t             dec_bundle_o,
  input  logic [`FETCH_CSR_AW-1:0]             s_axil_awaddr_i,
  input  logic                                 s_axil_awvalid_i,
  output logic                                 s_axil_awready_o,
  input  logic [31:0]                          s_axil_wdata_i,
  input  logic [3:0]                           s_axil_wstrb_i,
  input  logic                                 s_axil_wvalid_i,
  output logic                                 s_axil_wready_o,
  output logic [1:0]                           s_axil_bresp_o,
  output logic                                 s_axil_bvalid_o,
  input  logic                                 s_axil_bready_i,
  input  logic [`FETCH_CSR_AW-1:0]             s_axil_araddr_i,
  input  logic                                 s_axil_arvalid_i,
  output logic                                 s_axil_arready_o,
  output logic [31:0]                          s_axil_rdata_o,
  output logic [1:0]                           s_axil_rresp_o,
  output logic                                 s_axil_rvalid_o,
  input  logic                                 s_axil_rready_i
);

  import fetch_pkg::*;

  logic                     load;
  logic                     advance;
  redirect_t                flush_redir;
  redirect_t                override;
  f0_payload_t              f0_payload;
  f0_payload_t              f1_payload;
  btb_write_t               btb_wr;
  fetch_bundle_t            f1_bundle;
  fetch_ctrl_t              ctrl;
  logic                     btb_hit;
  logic [`FETCH_SLOT_W-1:0] btb_slot;
  logic [`FETCH_PC_W-1:0]   btb_target;

  // a flush always loads, even into a full buffer
  assign load    = !instbuf_full_i || flush_i;
  // edges where the f1 bundle really moves into d0
  assign advance = load && !flush_i;

  assign flush_redir.valid = flush_i;
  assign flush_redir.pc    = flush_pc_i;

  ////////////////////
  // f0
  ////////////////////
  fetch_pc_gen pc_gen_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .load_i       (load),
    .flush_i      (flush_redir),
    .override_i   (override),
    .btb_hit_i    (btb_hit),
    .btb_slot_i   (btb_slot),
    .btb_target_i (btb_target),
    .fetch_pc_o   (fetch_pc_o),
    .f0_o         (f0_payload)
  );

  fetch_btb btb_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .ctrl_i      (ctrl),
    .lookup_pc_i (fetch_pc_o),
    .write_i     (btb_wr),
    .hit_o       (btb_hit),
    .slot_o      (btb_slot),
    .target_o    (btb_target)
  );

  fetch_stage_reg #(.payload_t(f0_payload_t)) f1_reg_i (
    .clock   (clock),
    .reset_n (reset_n),
    .load_i  (load),
    .flush_i (flush_i),
    .data_i  (f0_payload),
    .data_o  (f1_payload)
  );

  ////////////////////
  // f1
  ////////////////////
  branch_decode br_dec_i (
    .f1_i          (f1_payload),
    .inst_bundle_i (inst_bundle_i),
    .btb_write_o   (btb_wr),
    .override_o    (override),
    .bundle_o      (f1_bundle)
  );

  fetch_stage_reg #(.payload_t(fetch_bundle_t)) d0_reg_i (
    .clock   (clock),
    .reset_n (reset_n),
    .load_i  (load),
    .flush_i (flush_i),
    .data_i  (f1_bundle),
    .data_o  (dec_bundle_o)
  );

  fetch_csr csr_i (
    .clock            (clock),
    .reset_n          (reset_n),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .override_i       (override.valid && advance),
    .bundle_valid_i   ((|f1_bundle.valid) && advance),
    .ctrl_o           (ctrl)
  );

endmodule

// File: verilog/fetch_csr.sv
// AXI4-Lite register block of the fetch unit
// CTRL with BTB enable and clear, bundle and override counters
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_csr (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic [`FETCH_CSR_AW-1:0] s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  logic [31:0]              s_axil_wdata_i,
  input  logic [3:0]               s_axil_wstrb_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  input  logic [`FETCH_CSR_AW-1:0] s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [31:0]              s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i,
  input  logic                     override_i,
  input  logic                     bundle_valid_i,
  output fetch_pkg::fetch_ctrl_t   ctrl_o
);

  logic        wr_fire;
  logic        ctrl_wr;
  logic        btb_enable_q;
  logic        btb_clear_q;
  logic [31:0] bundle_cnt;
  logic [31:0] override_cnt;

  ////////////////////
  // write channel
  ////////////////////
  // address and data are taken together, one response outstanding
  assign s_axil_awready_o = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
  assign s_axil_wready_o  = s_axil_awready_o;
  assign wr_fire          = s_axil_awready_o;
  assign ctrl_wr = wr_fire && (s_axil_awaddr_i == `CSR_CTRL) && s_axil_wstrb_i[0];
  assign s_axil_bresp_o   = 2'b00;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      s_axil_bvalid_o <= 1'b0;
      btb_enable_q    <= 1'b0;
      btb_clear_q     <= 1'b0;
    end else begin
      if (wr_fire) begin
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
      if (ctrl_wr) begin
        btb_enable_q <= s_axil_wdata_i[0];
      end
      // clear lasts a single cycle
      btb_clear_q <= ctrl_wr && s_axil_wdata_i[1];
    end
  end

  ////////////////////
  // counters
  ////////////////////
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      bundle_cnt   <= '0;
      override_cnt <= '0;
    end else begin
      bundle_cnt   <= bundle_cnt + 32'(bundle_valid_i);
      override_cnt <= override_cnt + 32'(override_i);
    end
  end

  ////////////////////
  // read channel
  ////////////////////
  assign s_axil_arready_o = !s_axil_rvalid_o;
  assign s_axil_rresp_o   = 2'b00;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      s_axil_rvalid_o <= 1'b0;
      s_axil_rdata_o  <= '0;
    end else if (s_axil_arvalid_i && s_axil_arready_o) begin
      s_axil_rvalid_o <= 1'b1;
      case (s_axil_araddr_i)
        `CSR_CTRL:      s_axil_rdata_o <= {31'b0, btb_enable_q};
        `CSR_BUNDLES:   s_axil_rdata_o <= bundle_cnt;
        `CSR_OVERRIDES: s_axil_rdata_o <= override_cnt;
        default:        s_axil_rdata_o <= '0;
      endcase
    end else if (s_axil_rready_i) begin
      s_axil_rvalid_o <= 1'b0;
    end
  end

  assign ctrl_o.btb_enable = btb_enable_q;
  assign ctrl_o.btb_clear  = btb_clear_q;

  // write response must wait for the master
  a_bvalid_hold: assert property (
    @(posedge clock) disable iff (!reset_n)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o
  );

endmodule

// File: verilog/branch_decode.sv
// f1 scan for the first BR or BSR in the bundle
// branch target, override decision and BTB training
`timescale 1ns/1ps
`include "fetch_defines.svh"

module branch_decode (
  input  fetch_pkg::f0_payload_t                       f1_i,
  input  logic [`FETCH_SLOTS*`FETCH_INST_W-1:0]        inst_bundle_i,
  output fetch_pkg::btb_write_t                        btb_write_o,
  output fetch_pkg::redirect_t                         override_o,
  output fetch_pkg::fetch_bundle_t                     bundle_o
);

  logic [`FETCH_SLOTS-1:0][`FETCH_INST_W-1:0] inst;
  logic                                       found;
  logic [`FETCH_SLOT_W-1:0]                   br_slot;
  logic [`FETCH_PC_W-1:0]                     br_pc;
  logic [`FETCH_PC_W-1:0]                     br_target;
  logic                                       mispredict;
  logic [`FETCH_SLOTS-1:0]                    trim_mask;

  assign inst = inst_bundle_i;

  // walk down so the lowest matching slot wins
  always_comb begin
    found   = 1'b0;
    br_slot = '0;
    for (int i = `FETCH_SLOTS - 1; i >= 0; i--) begin
      if (f1_i.valid[i] &&
          (inst[i][31:26] == `FETCH_OP_BR || inst[i][31:26] == `FETCH_OP_BSR)) begin
        found   = 1'b1;
        br_slot = `FETCH_SLOT_W'(i);
      end
    end
  end

  // target is pc + 4 + 4 * sext(disp21)
  assign br_pc     = f1_i.pc + {br_slot, 2'b00};
  assign br_target = br_pc + `FETCH_PC_W'(4) +
                     {{(`FETCH_PC_W-23){inst[br_slot][20]}}, inst[br_slot][20:0], 2'b00};

  // BTB missed the branch or placed it in another slot
  assign mispredict = found && (!f1_i.btb_hit || (f1_i.btb_slot != br_slot));

  always_comb begin
    for (int i = 0; i < `FETCH_SLOTS; i++) begin
      trim_mask[i] = f1_i.valid[i] && (i <= int'(br_slot));
    end
  end

  assign override_o.valid = mispredict;
  assign override_o.pc    = br_target;

  assign btb_write_o.we     = mispredict;
  assign btb_write_o.pc     = f1_i.pc;
  assign btb_write_o.slot   = br_slot;
  assign btb_write_o.target = br_target;

  assign bundle_o.valid = mispredict ? trim_mask : f1_i.valid;
  assign bundle_o.inst  = inst;
  assign bundle_o.pc    = f1_i.pc;

endmodule

// File: verilog/fetch_stage_reg.sv
// pipeline register for any packed payload
// load enable, flush clears the payload
`timescale 1ns/1ps

module fetch_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset_n,
  input  logic     load_i,
  input  logic     flush_i,
  input  payload_t data_i,
  output payload_t data_o
);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      data_o <= '0;
    end else if (flush_i) begin
      data_o <= '0;
    end else if (load_i) begin
      data_o <= data_i;
    end
  end

  // the top level load rule must force a load on every flush
  a_flush_loads: assert property (
    @(posedge clock) disable iff (!reset_n) flush_i |-> load_i
  );

endmodule

// File: verilog/fetch_btb.sv
// direct mapped branch target buffer
// combinational f0 lookup, f1 write, clear pulse
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_btb (
  input  logic                      clock,
  input  logic                      reset_n,
  input  fetch_pkg::fetch_ctrl_t    ctrl_i,
  input  logic [`FETCH_PC_W-1:0]    lookup_pc_i,
  input  fetch_pkg::btb_write_t     write_i,
  output logic                      hit_o,
  output logic [`FETCH_SLOT_W-1:0]  slot_o,
  output logic [`FETCH_PC_W-1:0]    target_o
);

  localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
  // upper pc bits plus the word offset inside the bundle
  localparam int TAG_W = `FETCH_PC_W - 5 - IDX_W + 3;

  logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]              tag_q    [`FETCH_BTB_ENTRIES];
  logic [`FETCH_SLOT_W-1:0]      slot_q   [`FETCH_BTB_ENTRIES];
  logic [`FETCH_PC_W-1:0]        target_q [`FETCH_BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_en;

  ////////////////////
  // lookup
  ////////////////////
  assign rd_idx = lookup_pc_i[5 +: IDX_W];
  assign rd_tag = {lookup_pc_i[`FETCH_PC_W-1:5+IDX_W], lookup_pc_i[4:2]};

  assign hit_o    = ctrl_i.btb_enable && valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign slot_o   = slot_q[rd_idx];
  assign target_o = target_q[rd_idx];

  ////////////////////
  // training from f1
  ////////////////////
  assign wr_idx = write_i.pc[5 +: IDX_W];
  assign wr_tag = {write_i.pc[`FETCH_PC_W-1:5+IDX_W], write_i.pc[4:2]};
  // a disabled BTB is left untouched
  assign wr_en  = write_i.we && ctrl_i.btb_enable;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else if (ctrl_i.btb_clear) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      slot_q[wr_idx]   <= write_i.slot;
      target_q[wr_idx] <= write_i.target;
    end
  end

endmodule

// File: verilog/fetch_pc_gen.sv
// f0 fetch pc register and next pc selection
// valid mask from the BTB predicted slot
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_pc_gen (
  input  logic                      clock,
  input  logic                      reset_n,
  input  logic                      load_i,
  input  fetch_pkg::redirect_t      flush_i,
  input  fetch_pkg::redirect_t      override_i,
  input  logic                      btb_hit_i,
  input  logic [`FETCH_SLOT_W-1:0]  btb_slot_i,
  input  logic [`FETCH_PC_W-1:0]    btb_target_i,
  output logic [`FETCH_PC_W-1:0]    fetch_pc_o,
  output fetch_pkg::f0_payload_t    f0_o
);

  logic [`FETCH_PC_W-1:0]  pc_q;
  logic [`FETCH_PC_W-1:0]  pc_next;
  logic [`FETCH_SLOTS-1:0] btb_mask;

  // retire flush beats f1 override beats BTB beats fall through
  always_comb begin
    if (flush_i.valid) begin
      pc_next = flush_i.pc;
    end else if (override_i.valid) begin
      pc_next = override_i.pc;
    end else if (btb_hit_i) begin
      pc_next = btb_target_i;
    end else begin
      pc_next = pc_q + `FETCH_PC_W'(32);
    end
  end

  // keep slots up to and including the predicted branch
  always_comb begin
    for (int i = 0; i < `FETCH_SLOTS; i++) begin
      btb_mask[i] = !btb_hit_i || (i <= int'(btb_slot_i));
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (load_i) begin
      pc_q <= pc_next;
    end
  end

  assign fetch_pc_o = pc_q;

  // an override squashes the bundle being fetched now
  assign f0_o.pc       = pc_q;
  assign f0_o.valid    = override_i.valid ? '0 : btb_mask;
  assign f0_o.btb_hit  = btb_hit_i;
  assign f0_o.btb_slot = btb_slot_i;

  // redirect targets from retire and f1 must keep fetch word aligned
  a_pc_aligned: assert property (
    @(posedge clock) disable iff (!reset_n) pc_q[1:0] == 2'b00
  );

endmodule

// File: verilog/fetch_pkg.sv
// packed struct types shared by the fetch stages
// bundle, f0 payload, BTB write, redirect and control
`include "fetch_defines.svh"

package fetch_pkg;

  // bundle handed to decode, 328 bits
  typedef struct packed {
    logic [`FETCH_SLOTS-1:0]                    valid;
    logic [`FETCH_SLOTS-1:0][`FETCH_INST_W-1:0] inst;
    logic [`FETCH_PC_W-1:0]                     pc;
  } fetch_bundle_t;

  // f0 to f1 payload, 76 bits
  typedef struct packed {
    logic [`FETCH_PC_W-1:0]   pc;
    logic [`FETCH_SLOTS-1:0]  valid;
    logic                     btb_hit;
    logic [`FETCH_SLOT_W-1:0] btb_slot;
  } f0_payload_t;

  // pc is the bundle pc that fetched the branch
  typedef struct packed {
    logic                     we;
    logic [`FETCH_PC_W-1:0]   pc;
    logic [`FETCH_SLOT_W-1:0] slot;
    logic [`FETCH_PC_W-1:0]   target;
  } btb_write_t;

  // override from f1 or flush from retire
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_PC_W-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic btb_enable;
    logic btb_clear;
  } fetch_ctrl_t;

endpackage

// File: verilog/fetch_defines.svh
// widths, sizes and opcodes for the fetch unit
// register byte offsets of the fetch control block
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

`define FETCH_PC_W         64
`define FETCH_INST_W       32
`define FETCH_SLOTS        8
`define FETCH_SLOT_W       3
`define FETCH_BTB_ENTRIES  16
`define FETCH_RESET_PC     64'h0000_0000_0000_1000

// unconditional direct branch major opcodes
`define FETCH_OP_BR        6'h30
`define FETCH_OP_BSR       6'h34

`define FETCH_CSR_AW       4
`define CSR_CTRL           4'h0
`define CSR_BUNDLES        4'h4
`define CSR_OVERRIDES      4'h8

`endif
